/* logic/mac_defs.svh */
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// Sample and bias width
`define MAC_DATA_W      8
`define MAC_PROD_W      16
// Accumulator and adder width
`define MAC_ACC_W       28
// Bias word and packed output word
`define MAC_WORD_W      32
`define MAC_LANES       4

`define MAC_MUL_STAGES  8   // Multiplier latency in cycles
`define MAC_FRAC_SHIFT  6   // Bias alignment and requantize shift

// 32 words of four biases, 128 channels
`define MAC_BIAS_WORDS  32

`endif

/* logic/mac_pkg.sv */
`default_nettype none

`include "mac_defs.svh"

package mac_pkg;

  typedef logic signed [`MAC_DATA_W-1:0] data_t;   // Sample or bias
  typedef logic signed [`MAC_PROD_W-1:0] prod_t;
  typedef logic signed [`MAC_ACC_W-1:0]  acc_t;    // Running channel sum

  // Upper bits pick the bias word, lower bits the lane
  typedef logic [$clog2(`MAC_BIAS_WORDS)+$clog2(`MAC_LANES)-1:0] chan_t;

  // Bias word, written whole and read one lane at a time
  // Lane 0 sits in the top byte and belongs to the lowest channel
  typedef union packed {
    logic [`MAC_WORD_W-1:0]   word;
    data_t [0:`MAC_LANES-1]   lane;
  } bias_word_u;

endpackage

`default_nettype wire

/* logic/cla_adder.sv */
`timescale 1ns/1ns
`default_nettype none

module cla_adder #(
  parameter int width = 28   // Multiple of 4
) (
  input  wire [width-1:0]  a,
  input  wire [width-1:0]  b,
  output logic [width-1:0] sum
);

  localparam int groups = width / 4;

  logic [width-1:0]  p;        // Bit propagate
  logic [width-1:0]  g;        // Bit generate
  logic [width-1:0]  c;        // Carry into each bit
  logic [groups-1:0] gp;
  logic [groups-1:0] gg;
  logic [groups-1:0] gc;       // Carry into each group

  assign p = a ^ b;
  assign g = a & b;
  assign gc[0] = 1'b0;

  for (genvar gi = 0; gi < groups; gi++) begin : grp
    localparam int lsb = 4 * gi;

    // Carries inside the group straight from the group carry-in
    assign c[lsb]   = gc[gi];
    assign c[lsb+1] = g[lsb] | (p[lsb] & gc[gi]);
    assign c[lsb+2] = g[lsb+1] | (p[lsb+1] & g[lsb]) | (&p[lsb+1:lsb] & gc[gi]);
    assign c[lsb+3] = g[lsb+2] | (p[lsb+2] & g[lsb+1]) | (&p[lsb+2:lsb+1] & g[lsb])
                    | (&p[lsb+2:lsb] & gc[gi]);

    assign gp[gi] = &p[lsb+3:lsb];
    assign gg[gi] = g[lsb+3] | (p[lsb+3] & g[lsb+2]) | (&p[lsb+3:lsb+2] & g[lsb+1])
                  | (&p[lsb+3:lsb+1] & g[lsb]);

    // Lookahead into the next group
    if (gi < groups - 1) begin : nxt
      assign gc[gi+1] = gg[gi] | (gp[gi] & gc[gi]);
    end
  end

  assign sum = p ^ c;

endmodule

`default_nettype wire

/* logic/shift_add_mul.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module shift_add_mul (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  sample_valid,
  input  wire mac_pkg::data_t  feat,
  input  wire mac_pkg::data_t  weight,
  input  wire                  first,
  input  wire                  last,
  output mac_pkg::prod_t       prod,
  output logic                 prod_valid,
  output logic                 prod_first,
  output logic                 prod_last
);

  localparam int n = `MAC_MUL_STAGES;

  mac_pkg::data_t feat_q, weight_q;              // Input register
  logic [7:0]  a_mag, b_mag;
  logic [7:0]  pp_q [8];                         // Stage 1 partial products
  logic [5:0]  lsb2_q [4];
  logic [2:0]  hi2a_q [4];
  logic [3:0]  hi2b_q [4];
  logic [4:0]  msb3 [4];
  logic [9:0]  sum3_q [4];
  logic [7:0]  lsb4_q [2];
  logic [2:0]  hi4a_q [2];
  logic [4:0]  hi4b_q [2];
  logic [4:0]  msb5 [2];
  logic [11:0] sum5_q [2];
  logic [9:0]  lsb6_q;
  logic [2:0]  hi6a_q;
  logic [6:0]  hi6b_q;
  logic [6:0]  msb7;
  logic [15:0] mag_q;
  logic [n-2:0] sign_q;                          // Stages 1 to 7
  logic [n:0]  vld_q, first_q, last_q;

  assign a_mag = feat_q[7] ? 8'(-feat_q) : feat_q;
  assign b_mag = weight_q[7] ? 8'(-weight_q) : weight_q;

  for (genvar j = 0; j < 4; j++) begin : hi3
    assign msb3[j] = hi2a_q[j] + hi2b_q[j] + lsb2_q[j][5];
  end
  for (genvar k = 0; k < 2; k++) begin : hi5
    assign msb5[k] = hi4a_q[k] + hi4b_q[k] + lsb4_q[k][7];
  end
  assign msb7 = hi6a_q + hi6b_q + lsb6_q[9];

  //////////////////////////////////////////////////
  // Datapath, always advancing
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    feat_q   <= feat;
    weight_q <= weight;
    for (int i = 0; i < 8; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : 8'h00;
    end
    sign_q <= {sign_q[n-3:0], feat_q[7] ^ weight_q[7]};
    // Pairs, low half first
    for (int j = 0; j < 4; j++) begin
      lsb2_q[j] <= pp_q[2*j][4:0] + {pp_q[2*j+1][3:0], 1'b0};
      hi2a_q[j] <= pp_q[2*j][7:5];
      hi2b_q[j] <= pp_q[2*j+1][7:4];
      sum3_q[j] <= {msb3[j], lsb2_q[j][4:0]};
    end
    // Quads, shift by two
    for (int k = 0; k < 2; k++) begin
      lsb4_q[k] <= sum3_q[2*k][6:0] + {sum3_q[2*k+1][4:0], 2'b00};
      hi4a_q[k] <= sum3_q[2*k][9:7];
      hi4b_q[k] <= sum3_q[2*k+1][9:5];
      sum5_q[k] <= {msb5[k], lsb4_q[k][6:0]};
    end
    // Final pair, shift by four
    lsb6_q <= sum5_q[0][8:0] + {sum5_q[1][4:0], 4'b0000};
    hi6a_q <= sum5_q[0][11:9];
    hi6b_q <= sum5_q[1][11:5];
    mag_q  <= {msb7, lsb6_q[8:0]};
    prod   <= sign_q[n-2] ? -$signed(mag_q) : $signed(mag_q);   // Restore sign
  end

  // Flags ride along with the data
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_q   <= '0;
      first_q <= '0;
      last_q  <= '0;
    end else begin
      vld_q   <= {vld_q[n-1:0], sample_valid};
      first_q <= {first_q[n-1:0], sample_valid & first};
      last_q  <= {last_q[n-1:0], sample_valid & last};
    end
  end

  assign prod_valid = vld_q[n];
  assign prod_first = first_q[n];
  assign prod_last  = last_q[n];

endmodule

`default_nettype wire

/* logic/bias_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module bias_bank (
  input  wire                                 clk,
  input  wire                                 rstn,
  input  wire                                 bias_we,
  input  wire [$clog2(`MAC_BIAS_WORDS)-1:0]   bias_waddr,
  input  wire mac_pkg::bias_word_u            bias_wdata,
  input  wire                                 layer_start,
  input  wire                                 sample_valid,
  input  wire                                 last,
  output mac_pkg::data_t                      bias
);

  localparam int lane_bits = $clog2(`MAC_LANES);
  localparam int chan_bits = $bits(mac_pkg::chan_t);

  mac_pkg::bias_word_u mem [`MAC_BIAS_WORDS];
  mac_pkg::chan_t      chan;                        // Channel of the next last tap
  mac_pkg::data_t      bias_sel;
  mac_pkg::data_t      bias_dly [`MAC_MUL_STAGES];

  always_ff @(posedge clk) begin
    if (bias_we) begin
      mem[bias_waddr] <= bias_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      chan <= '0;
    end else if (layer_start) begin
      chan <= '0;
    end else if (sample_valid && last) begin
      chan <= chan + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Lane select and delay to the product
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (sample_valid && last) begin
      bias_sel <= mem[chan[chan_bits-1:lane_bits]].lane[chan[lane_bits-1:0]];
    end
    bias_dly[0] <= bias_sel;
    for (int i = 1; i < `MAC_MUL_STAGES; i++) begin
      bias_dly[i] <= bias_dly[i-1];
    end
  end

  assign bias = bias_dly[`MAC_MUL_STAGES-1];   // Lines up with prod_last

endmodule

`default_nettype wire

/* logic/acc_quant.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module acc_quant (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire                     lane_clear,
  input  wire mac_pkg::prod_t     prod,
  input  wire                     prod_valid,
  input  wire                     prod_first,
  input  wire                     prod_last,
  input  wire mac_pkg::data_t     bias,
  output logic                    out_valid,
  output logic [`MAC_WORD_W-1:0]  out_word
);

  localparam int lane_bits = $clog2(`MAC_LANES);
  localparam int sext_prod = `MAC_ACC_W - `MAC_PROD_W;
  localparam int sext_bias = `MAC_ACC_W - `MAC_DATA_W - `MAC_FRAC_SHIFT;
  localparam int sat_lsb   = `MAC_FRAC_SHIFT + `MAC_DATA_W - 1;   // Lowest overflow bit

  mac_pkg::acc_t acc_q;
  mac_pkg::acc_t acc_base;
  mac_pkg::acc_t prod_ext;
  mac_pkg::acc_t acc_next;
  mac_pkg::acc_t bias_ext;
  mac_pkg::acc_t biased;
  logic [`MAC_DATA_W-1:0]                q_byte;
  logic [lane_bits-1:0]                  lane;
  logic [(`MAC_LANES-1)*`MAC_DATA_W-1:0] pack_q;   // Lanes waiting for the top one

  assign prod_ext = {{sext_prod{prod[`MAC_PROD_W-1]}}, prod};
  assign acc_base = prod_first ? '0 : acc_q;        // First tap restarts the sum

  cla_adder #(.width(`MAC_ACC_W)) sum_add (
    .a   (prod_ext),
    .b   (acc_base),
    .sum (acc_next)
  );

  assign bias_ext = {{sext_bias{bias[`MAC_DATA_W-1]}}, bias, {`MAC_FRAC_SHIFT{1'b0}}};

  cla_adder #(.width(`MAC_ACC_W)) bias_add (
    .a   (acc_next),
    .b   (bias_ext),
    .sum (biased)
  );

  // Clamp to 0..127
  always_comb begin
    if (biased[`MAC_ACC_W-1]) begin
      q_byte = '0;
    end else if (|biased[`MAC_ACC_W-2:sat_lsb]) begin
      q_byte = {1'b0, {(`MAC_DATA_W-1){1'b1}}};
    end else begin
      q_byte = {1'b0, biased[sat_lsb-1:`MAC_FRAC_SHIFT]};
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc_q <= acc_next;
    end
    if (prod_valid && prod_last) begin
      if (lane == lane_bits'(`MAC_LANES - 1)) begin
        out_word <= {q_byte, pack_q};                 // Channel 0 ends up in the low byte
      end else begin
        pack_q[lane*`MAC_DATA_W +: `MAC_DATA_W] <= q_byte;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane      <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (lane_clear) begin
        lane <= '0;
      end else if (prod_valid && prod_last) begin
        lane      <= lane + 1'b1;
        out_valid <= (lane == lane_bits'(`MAC_LANES - 1));
      end
    end
  end

endmodule

`default_nettype wire

/* logic/conv_mac.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module conv_mac (
  input  wire                                 clk,
  input  wire                                 rstn,
  input  wire                                 sample_valid,
  input  wire mac_pkg::data_t                 feat,
  input  wire mac_pkg::data_t                 weight,
  input  wire                                 first,
  input  wire                                 last,
  input  wire                                 layer_start,
  input  wire                                 bias_we,
  input  wire [$clog2(`MAC_BIAS_WORDS)-1:0]   bias_waddr,
  input  wire mac_pkg::bias_word_u            bias_wdata,
  output logic                                out_valid,
  output logic [`MAC_WORD_W-1:0]              out_word
);

  wire mac_pkg::prod_t prod;
  wire                 prod_valid;
  wire                 prod_first;
  wire                 prod_last;
  wire mac_pkg::data_t bias;     // Already aligned to prod_last

  shift_add_mul mul_i (
    .clk          (clk),
    .rstn         (rstn),
    .sample_valid (sample_valid),
    .feat         (feat),
    .weight       (weight),
    .first        (first),
    .last         (last),
    .prod         (prod),
    .prod_valid   (prod_valid),
    .prod_first   (prod_first),
    .prod_last    (prod_last)
  );

  bias_bank bias_i (
    .clk          (clk),
    .rstn         (rstn),
    .bias_we      (bias_we),
    .bias_waddr   (bias_waddr),
    .bias_wdata   (bias_wdata),
    .layer_start  (layer_start),
    .sample_valid (sample_valid),
    .last         (last),
    .bias         (bias)
  );

  acc_quant acc_i (
    .clk          (clk),
    .rstn         (rstn),
    .lane_clear   (layer_start),
    .prod         (prod),
    .prod_valid   (prod_valid),
    .prod_first   (prod_first),
    .prod_last    (prod_last),
    .bias         (bias),
    .out_valid    (out_valid),
    .out_word     (out_word)
  );

endmodule

`default_nettype wire

/* test/conv_mac_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module conv_mac_props (
  input wire                    clk,
  input wire                    rstn,
  input wire                    out_valid,
  input wire [`MAC_WORD_W-1:0]  out_word,
  input wire                    prod_last
);

  //////////////////////////////////////////////////
  // Output word checks
  //////////////////////////////////////////////////

  // Held in reset for a second edge
  a_quiet_in_reset: assert property (@(posedge clk) !rstn && $past(!rstn) |-> !out_valid)
    else $error("out_valid high during reset");

  a_bytes_in_range: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> (out_word & 32'h8080_8080) == 32'h0)
    else $error("Output byte above 127");

  a_pulse_after_last: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> $past(prod_last))   // One edge from prod_last
    else $error("out_valid without prod_last the cycle before");

endmodule

`default_nettype wire

/* test/conv_mac_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module conv_mac_tb;

  localparam int n_ent      = 14;
  localparam int restart_at = 6;                    // First entry of the second layer
  localparam int aw         = $clog2(`MAC_BIAS_WORDS);
  localparam int rnd = 0, pos = 1, neg = 2, mix = 3;

  logic                   clk = 1'b0;
  logic                   rstn, sample_valid, first, last, layer_start, bias_we;
  mac_pkg::data_t         feat, weight;
  logic [aw-1:0]          bias_waddr;
  logic [`MAC_WORD_W-1:0] bias_wdata;
  wire                    out_valid;
  wire [`MAC_WORD_W-1:0]  out_word;

  int tbl_taps [n_ent];
  int tbl_bias [n_ent];
  int tbl_mode [n_ent];
  int tbl_gap [n_ent];
  int tbl_exp [n_ent];                              // -1 where the model supplies the byte
  logic [`MAC_WORD_W-1:0] exp_q [$];
  logic [31:0] seed = 32'hb806_8520;
  int errors = 0, checks = 0, words = 0, cycles = 0, limit = 200;

  always #4 clk = ~clk;

  conv_mac conv_mac_i (
    .clk          (clk),
    .rstn         (rstn),
    .sample_valid (sample_valid),
    .feat         (feat),
    .weight       (weight),
    .first        (first),
    .last         (last),
    .layer_start  (layer_start),
    .bias_we      (bias_we),
    .bias_waddr   (bias_waddr),
    .bias_wdata   (bias_wdata),
    .out_valid    (out_valid),
    .out_word     (out_word)
  );

  bind conv_mac conv_mac_props props_i (
    .clk       (clk),
    .rstn      (rstn),
    .out_valid (out_valid),
    .out_word  (out_word),
    .prod_last (prod_last)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Drop the fraction bits and clamp to 0..127
  function automatic int clamp_byte(input int total);
    if (total < 0) begin
      return 0;
    end
    return (total >= (128 << `MAC_FRAC_SHIFT)) ? 127 : total >>> `MAC_FRAC_SHIFT;
  endfunction

  task automatic set_entry(input int i, t, b, m, g, e);
    tbl_taps[i] = t;
    tbl_bias[i] = b;
    tbl_mode[i] = m;
    tbl_gap[i]  = g;
    tbl_exp[i]  = e;
  endtask

  task automatic tap_operands(input int m, t, output mac_pkg::data_t f, w);
    seed = lcg(seed);
    if (m == rnd) begin
      f = seed[23:16];
      w = {{3{seed[12]}}, seed[12:8]};              // Small weights keep some sums in range
    end else if (m == mix) begin
      f = (t % 2 == 0) ? 8'sd1 : 8'sh80;            // 1 x 64, then -128 x 127
      w = (t % 2 == 0) ? 8'sd64 : 8'sd127;
    end else begin
      f = (m == pos) ? 8'sd127 : 8'sh80;
      w = f;
    end
  endtask

  task automatic drive(input logic v, input mac_pkg::data_t f, w, input logic fi, la);
    @(posedge clk);
    sample_valid <= v;
    feat         <= f;
    weight       <= w;
    first        <= fi;
    last         <= la;
  endtask

  // Four channels per word, lowest channel in the top byte
  task automatic load_biases(input int lo, hi);
    logic [31:0] word;
    for (int c = 0; c < hi - lo; c += 4) begin
      word = '0;
      for (int l = 0; l < 4 && c + l < hi - lo; l++) begin
        word[31-8*l -: 8] = 8'(tbl_bias[lo+c+l]);
      end
      @(posedge clk);
      bias_we    <= 1'b1;
      bias_waddr <= aw'(c / 4);
      bias_wdata <= word;
    end
    @(posedge clk);
    bias_we <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Result capture and run limit
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstn && out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Result word appeared at %0t with no result pending", $time);
      end else begin
        checks++;
        if (out_word !== exp_q[0]) begin
          errors++;
          $display("error at %0t: out_word %h, expected %h", $time, out_word, exp_q[0]);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Run stopped after %0d cycles with results still pending", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    mac_pkg::data_t f, w;
    int sum;
    int byte_v;
    int lane;
    logic [31:0] word;
    //        idx taps bias  mode gap exp
    set_entry(0,  1,   0,    neg, 0,  127);
    set_entry(1,  1,   0,    mix, 0,  1);
    set_entry(2,  4,   3,    rnd, 1,  -1);
    set_entry(3,  9,   0,    pos, 0,  127);
    set_entry(4,  9,   10,   rnd, 0,  -1);          // Dropped by layer_start
    set_entry(5,  1,   0,    mix, 1,  1);           // Dropped by layer_start
    set_entry(6,  1,   -2,   mix, 0,  0);
    set_entry(7,  1,   5,    mix, 0,  6);
    set_entry(8,  3,   -7,   rnd, 1,  -1);
    set_entry(9,  2,   0,    mix, 0,  0);
    set_entry(10, 1,   -128, pos, 0,  124);
    set_entry(11, 1,   127,  mix, 1,  127);         // Lands exactly on 128.0
    set_entry(12, 5,   1,    rnd, 0,  -1);
    set_entry(13, 2,   -128, neg, 0,  127);
    for (int i = 0; i < n_ent; i++) begin
      limit += tbl_taps[i] * (1 + tbl_gap[i]);
    end
    rstn = 1'b0;
    sample_valid = 1'b0;
    feat = '0;
    weight = '0;
    first = 1'b0;
    last = 1'b0;
    layer_start = 1'b0;
    bias_we = 1'b0;
    bias_waddr = '0;
    bias_wdata = '0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    load_biases(0, restart_at);
    lane = 0;
    word = '0;
    for (int i = 0; i < n_ent; i++) begin
      if (i == restart_at) begin
        drive(1'b0, '0, '0, 1'b0, 1'b0);
        repeat (`MAC_MUL_STAGES + 2) @(posedge clk);   // Pipeline empty
        load_biases(restart_at, n_ent);
        layer_start <= 1'b1;
        @(posedge clk);
        layer_start <= 1'b0;
        lane = 0;
      end
      sum = 0;
      for (int t = 0; t < tbl_taps[i]; t++) begin
        tap_operands(tbl_mode[i], t, f, w);
        sum += int'(f) * int'(w);
        drive(1'b1, f, w, t == 0, t == tbl_taps[i] - 1);
        if (tbl_gap[i] != 0) begin
          seed = lcg(seed);
          drive(1'b0, seed[31:24], seed[15:8], 1'b1, 1'b1);
        end
      end
      byte_v = (tbl_exp[i] >= 0) ? tbl_exp[i]
             : clamp_byte(sum + tbl_bias[i] * (1 << `MAC_FRAC_SHIFT));
      word[8*lane +: 8] = 8'(byte_v);
      lane++;
      if (lane == `MAC_LANES) begin
        exp_q.push_back(word);
        words++;
        lane = 0;
      end
    end
    drive(1'b0, '0, '0, 1'b0, 1'b0);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (`MAC_MUL_STAGES + 4) @(posedge clk);   // Catch a stray pulse
    $display("Words %0d, checked %0d, errors %0d", words, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/mac_pkg.sv
logic/cla_adder.sv
logic/shift_add_mul.sv
logic/bias_bank.sv
logic/acc_quant.sv
logic/conv_mac.sv
test/conv_mac_props.sv
test/conv_mac_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module conv_mac_tb -f list.f \
  && ./obj_dir/Vconv_mac_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
